//--- design/isa_pkg.sv
package isa_pkg;

    // ----------------------------------------------------------
    // rv32 word and field widths
    // ----------------------------------------------------------

    localparam int WORD_LEN  = 32;
    localparam int SHAMT_LEN = 5;
    localparam int FUNC3_LEN = 3;

    // ----------------------------------------------------------
    // func3 encodings of the OP / OP-IMM groups
    // ----------------------------------------------------------

    // base group names
    typedef enum logic [FUNC3_LEN-1:0] {
        ADD = 3'd0,
        SL  = 3'd1,
        XOR = 3'd4,
        SR  = 3'd5,
        OR  = 3'd6,
        AND = 3'd7
    } func3_e;

    // M-extension reuses the same codes
    localparam func3_e DIVU = SR;
    localparam func3_e REM  = OR;
    localparam func3_e REMU = AND;

endpackage

//--- design/exec_pkg.sv
package exec_pkg;

    // decoded operation handed from issue to execute
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_DIVU,
        OP_REMU,
        // unsupported extension code, result is zero
        OP_ZERO
    } alu_op_e;

    // one quotient bit per step
    localparam int DIV_STEPS   = 32;
    localparam int DIV_CNT_LEN = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } div_state_e;

endpackage

//--- design/exec_if.sv
`timescale 1ns/1ps

interface exec_if;

    // held steady while issue_valid is high
    logic                         issue_valid;
    exec_pkg::alu_op_e            op;
    logic [isa_pkg::WORD_LEN-1:0] a;
    logic [isa_pkg::WORD_LEN-1:0] b;

    // one cycle, execute stage consumes the item
    logic                         issue_take;

    modport issue (
        output issue_valid,
        output op,
        output a,
        output b,
        input  issue_take
    );

    modport exec (
        input  issue_valid,
        input  op,
        input  a,
        input  b,
        output issue_take
    );

endinterface

//--- design/op_issue.sv
`timescale 1ns/1ps

`default_nettype none

module op_issue (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         order,
    input  wire isa_pkg::func3_e              func3,
    input  wire logic                         mode_flag,
    input  wire logic                         imm_flag,
    input  wire logic                         extension_flag,
    input  wire logic [isa_pkg::WORD_LEN-1:0] rs1,
    input  wire logic [isa_pkg::WORD_LEN-1:0] rs2,
    output logic                              accepted,
    exec_if.issue                             link
);

    exec_pkg::alu_op_e dec_op;

    // register free, or emptied this cycle
    assign accepted = order && (!link.issue_valid || link.issue_take);

    // decode ------------------------------------------------------
    always_comb begin
        dec_op = exec_pkg::OP_ZERO;
        if (extension_flag) begin
            if (func3 == isa_pkg::DIVU)
                dec_op = exec_pkg::OP_DIVU;
            else if (func3 == isa_pkg::REMU)
                dec_op = exec_pkg::OP_REMU;
        end else begin
            case (func3)
                isa_pkg::ADD: dec_op = (mode_flag && !imm_flag) ? exec_pkg::OP_SUB
                                                                : exec_pkg::OP_ADD;
                isa_pkg::SL:  dec_op = exec_pkg::OP_SLL;
                isa_pkg::SR:  dec_op = mode_flag ? exec_pkg::OP_SRA : exec_pkg::OP_SRL;
                isa_pkg::XOR: dec_op = exec_pkg::OP_XOR;
                isa_pkg::OR:  dec_op = exec_pkg::OP_OR;
                isa_pkg::AND: dec_op = exec_pkg::OP_AND;
                default:      dec_op = exec_pkg::OP_ZERO;
            endcase
        end
    end

    // holding register ------------------------------------------
    always_ff @(posedge clk) begin
        if (rst)
            link.issue_valid <= 1'b0;
        else if (accepted)
            link.issue_valid <= 1'b1;
        else if (link.issue_take)
            link.issue_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            link.op <= dec_op;
            link.a  <= rs1;
            link.b  <= rs2;
        end
    end

    // execute stage may only take a held item
    a_take_held: assert property (@(posedge clk) disable iff (rst)
        link.issue_take |-> link.issue_valid);

endmodule

`default_nettype wire

//--- design/div_unsigned.sv
`timescale 1ns/1ps

`default_nettype none

module div_unsigned (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         start,
    input  wire logic [isa_pkg::WORD_LEN-1:0] dividend,
    input  wire logic [isa_pkg::WORD_LEN-1:0] divisor,
    input  wire logic                         want_rem,
    output logic                              done,
    output logic [isa_pkg::WORD_LEN-1:0]      result
);

    exec_pkg::div_state_e               state;
    logic [exec_pkg::DIV_CNT_LEN-1:0]   step;
    logic [isa_pkg::WORD_LEN-1:0]       rem;
    logic [isa_pkg::WORD_LEN-1:0]       quo;
    logic [isa_pkg::WORD_LEN-1:0]       dsor;
    logic                               rem_sel;
    logic [isa_pkg::WORD_LEN:0]         trial;
    logic [isa_pkg::WORD_LEN-1:0]       diff;
    logic                               fits;

    // one restoring step
    // quo doubles as the dividend shift register
    assign trial = {rem, quo[isa_pkg::WORD_LEN-1]};
    assign fits  = trial >= {1'b0, dsor};
    assign diff  = trial[isa_pkg::WORD_LEN-1:0] - dsor;

    // FSM --------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= exec_pkg::IDLE;
            step  <= '0;
        end else begin
            case (state)
                exec_pkg::IDLE: begin
                    if (start) begin
                        state <= exec_pkg::RUN;
                        step  <= '0;
                    end
                end
                exec_pkg::RUN: begin
                    step <= step + 1'b1;
                    if (step == exec_pkg::DIV_CNT_LEN'(exec_pkg::DIV_STEPS - 1))
                        state <= exec_pkg::FINISH;
                end
                default: state <= exec_pkg::IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == exec_pkg::IDLE && start) begin
            rem     <= '0;
            quo     <= dividend;
            dsor    <= divisor;
            rem_sel <= want_rem;
        end else if (state == exec_pkg::RUN) begin
            quo <= {quo[isa_pkg::WORD_LEN-2:0], fits};
            // zero divisor always fits: all ones, rem ends as dividend
            if (fits)
                rem <= diff;
            else
                rem <= trial[isa_pkg::WORD_LEN-1:0];
        end
    end

    assign done   = state == exec_pkg::FINISH;
    assign result = rem_sel ? rem : quo;

    // caller has to respect the busy window
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> state == exec_pkg::IDLE);

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps

`default_nettype none

module alu (
    input  wire logic                    clk,
    input  wire logic                    rst,
    exec_if.exec                         link,
    output logic                         done,
    output logic [isa_pkg::WORD_LEN-1:0] rd
);

    logic                          busy;
    logic                          take;
    logic                          is_div;
    logic                          div_start;
    logic                          div_done;
    logic [isa_pkg::WORD_LEN-1:0]  div_result;
    logic                          internal_done;
    logic [isa_pkg::WORD_LEN-1:0]  internal_rd;
    logic [isa_pkg::SHAMT_LEN-1:0] shamt;
    logic [isa_pkg::WORD_LEN-1:0]  rd_buf;
    logic [isa_pkg::WORD_LEN-1:0]  next_rd;

    assign is_div = (link.op == exec_pkg::OP_DIVU) || (link.op == exec_pkg::OP_REMU);

    // nothing is taken while the divider owns the stage
    assign take           = link.issue_valid && !busy;
    assign link.issue_take = take;

    assign div_start     = take && is_div;
    assign internal_done = take && !is_div;

    // busy covers the FINISH cycle too
    always_ff @(posedge clk) begin
        if (rst)
            busy <= 1'b0;
        else if (div_start)
            busy <= 1'b1;
        else if (div_done)
            busy <= 1'b0;
    end

    // divu / remu ------------------------------------------------
    div_unsigned u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (link.a),
        .divisor  (link.b),
        .want_rem (link.op == exec_pkg::OP_REMU),
        .done     (div_done),
        .result   (div_result)
    );

    // single-cycle path ------------------------------------------
    assign shamt = link.b[isa_pkg::SHAMT_LEN-1:0];

    always_comb begin
        case (link.op)
            exec_pkg::OP_ADD: internal_rd = link.a + link.b;
            exec_pkg::OP_SUB: internal_rd = link.a - link.b;
            exec_pkg::OP_SLL: internal_rd = link.a << shamt;
            exec_pkg::OP_SRL: internal_rd = link.a >> shamt;
            exec_pkg::OP_SRA: internal_rd = $unsigned($signed(link.a) >>> shamt);
            exec_pkg::OP_XOR: internal_rd = link.a ^ link.b;
            exec_pkg::OP_OR:  internal_rd = link.a | link.b;
            exec_pkg::OP_AND: internal_rd = link.a & link.b;
            default:          internal_rd = '0;
        endcase
    end

    // result buffer -----------------------------------------------
    assign done = div_done || internal_done;

    assign next_rd = div_done      ? div_result  :
                     internal_done ? internal_rd : rd_buf;

    always_ff @(posedge clk) begin
        if (rst)
            rd_buf <= '0;
        else
            rd_buf <= next_rd;
    end

    // new value already visible in the done cycle
    assign rd = next_rd;

    a_div_after_take: assert property (@(posedge clk) disable iff (rst)
        div_done |-> $past(div_start, exec_pkg::DIV_STEPS + 1));

    // busy window matches the divider FSM
    a_busy_div: assert property (@(posedge clk) disable iff (rst)
        busy == (u_div.state != exec_pkg::IDLE));

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ps

`default_nettype none

module exec_unit (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         order,
    input  wire isa_pkg::func3_e              func3,
    input  wire logic                         mode_flag,
    input  wire logic                         imm_flag,
    input  wire logic                         extension_flag,
    input  wire logic [isa_pkg::WORD_LEN-1:0] rs1,
    input  wire logic [isa_pkg::WORD_LEN-1:0] rs2,
    output logic                              accepted,
    output logic                              done,
    output logic [isa_pkg::WORD_LEN-1:0]      rd
);

    // issue -> execute link
    exec_if link ();

    op_issue u_issue (
        .clk            (clk),
        .rst            (rst),
        .order          (order),
        .func3          (func3),
        .mode_flag      (mode_flag),
        .imm_flag       (imm_flag),
        .extension_flag (extension_flag),
        .rs1            (rs1),
        .rs2            (rs2),
        .accepted       (accepted),
        .link           (link.issue)
    );

    alu u_alu (
        .clk  (clk),
        .rst  (rst),
        .link (link.exec),
        .done (done),
        .rd   (rd)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

//--- testbench/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;

    localparam int TIMEOUT = exec_pkg::DIV_STEPS + 10;

    typedef logic [isa_pkg::WORD_LEN-1:0] word_t;

    typedef struct {
        word_t           value;
        isa_pkg::func3_e op;
        logic            ext;
        logic            is_div;
        int              cycle;
        logic            idle;
    } expect_t;

    logic            clk, rst, order, mode_flag, imm_flag, extension_flag, accepted, done;
    isa_pkg::func3_e func3;
    word_t           rs1, rs2, rd;

    expect_t         exp_q[$];
    logic [15:0]     lfsr = 16'd36979;
    int              cycle = 0;
    int              value_errors = 0;
    int              other_errors = 0;
    int              stall_cycles = 0;
    word_t           last_rd = '0;

    tb_clock u_clock (.clk(clk));

    exec_unit dut (
        .clk(clk), .rst(rst), .order(order), .func3(func3), .mode_flag(mode_flag),
        .imm_flag(imm_flag), .extension_flag(extension_flag), .rs1(rs1), .rs2(rs2),
        .accepted(accepted), .done(done), .rd(rd)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------------------------------------
    // operands and expected results
    // ------------------------------------------------------------

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_word(output word_t w);
        w = '0;
        for (int i = 0; i < isa_pkg::WORD_LEN; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[isa_pkg::WORD_LEN-2:0], lfsr[0]};
        end
    endtask

    function automatic word_t ref_exec(input isa_pkg::func3_e f, input logic mode,
                                       input logic imm, input logic ext,
                                       input word_t a, input word_t b);
        logic [isa_pkg::SHAMT_LEN-1:0] sh;
        word_t                         fill;
        sh = b[isa_pkg::SHAMT_LEN-1:0];
        // copies of the sign bit shifted in from the top
        fill = a[isa_pkg::WORD_LEN-1] ? ~({isa_pkg::WORD_LEN{1'b1}} >> sh) : '0;
        if (ext) begin
            if (f == isa_pkg::DIVU)
                return (b == '0) ? {isa_pkg::WORD_LEN{1'b1}} : a / b;
            if (f == isa_pkg::REMU)
                return (b == '0) ? a : a % b;
            return '0;
        end
        case (f)
            isa_pkg::ADD: return (mode && !imm) ? a - b : a + b;
            isa_pkg::SL:  return a << sh;
            isa_pkg::SR:  return mode ? ((a >> sh) | fill) : (a >> sh);
            isa_pkg::XOR: return a ^ b;
            isa_pkg::OR:  return a | b;
            isa_pkg::AND: return a & b;
            default:      return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_op(input isa_pkg::func3_e op, input logic ext,
                            input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %s%s result expected %h actual %h", ext ? "ext " : "",
                     op.name(), exp, act);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ------------------------------------------------------------
    // checker, sampled mid-cycle
    // ------------------------------------------------------------

    always @(negedge clk) begin : result_check
        expect_t e;
        int      lat;
        if (!rst) begin
            if (done && exp_q.size() == 0) begin
                $display("done pulsed with no operation outstanding");
                other_errors++;
            end else if (done) begin
                e = exp_q.pop_front();
                check_op(e.op, e.ext, e.value, rd);
                lat = cycle - e.cycle;
                if (e.idle && lat != (e.is_div ? exec_pkg::DIV_STEPS + 2 : 1)) begin
                    $display("FAIL %s latency expected %0d actual %0d", e.op.name(),
                             e.is_div ? exec_pkg::DIV_STEPS + 2 : 1, lat);
                    value_errors++;
                end
            end
            if (done)
                last_rd = rd;
            else
                check_word("rd hold", last_rd, rd);
            if (accepted) begin
                e.value  = ref_exec(func3, mode_flag, imm_flag, extension_flag, rs1, rs2);
                e.op     = func3;
                e.ext    = extension_flag;
                e.is_div = extension_flag && (func3 == isa_pkg::DIVU || func3 == isa_pkg::REMU);
                e.cycle  = cycle;
                e.idle   = exp_q.size() == 0;
                exp_q.push_back(e);
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic send(input isa_pkg::func3_e f, input logic mode, input logic imm,
                        input logic ext, input word_t a, input word_t b);
        int waited;
        order          <= 1'b1;
        func3          <= f;
        mode_flag      <= mode;
        imm_flag       <= imm;
        extension_flag <= ext;
        rs1            <= a;
        rs2            <= b;
        waited = 0;
        @(negedge clk);
        while (!accepted && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        stall_cycles = waited;
        if (!accepted) begin
            $display("order %s was never accepted", f.name());
            other_errors++;
            finish_run();
        end else begin
            // capture edge
            @(posedge clk);
        end
    endtask

    task automatic drain();
        int waited;
        int left;
        waited = 0;
        left = exp_q.size();
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            if (exp_q.size() < left)
                waited = 0;
            else
                waited++;
            left = exp_q.size();
        end
        if (exp_q.size() != 0) begin
            $display("done never came for %0d outstanding operations", exp_q.size());
            other_errors++;
            finish_run();
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic run_one(input isa_pkg::func3_e f, input logic mode, input logic imm,
                           input logic ext, input word_t a, input word_t b);
        send(f, mode, imm, ext, a, b);
        order <= 1'b0;
        drain();
    endtask

    task automatic random_op(input isa_pkg::func3_e f, input logic mode, input logic imm,
                             input logic ext);
        word_t a;
        word_t b;
        rand_word(a);
        rand_word(b);
        run_one(f, mode, imm, ext, a, b);
    endtask

    initial begin
        word_t a;
        word_t b;
        order = 1'b0;
        func3 = isa_pkg::ADD;
        mode_flag = 1'b0;
        imm_flag = 1'b0;
        extension_flag = 1'b0;
        rs1 = '0;
        rs2 = '0;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (done || accepted) begin
            $display("done or accepted is high right after reset");
            other_errors++;
        end
        check_word("rd after reset", '0, rd);
        @(posedge clk);

        // base group
        for (int n = 0; n < 3; n++) begin
            random_op(isa_pkg::ADD, 1'b0, 1'b0, 1'b0);
            random_op(isa_pkg::ADD, 1'b1, 1'b0, 1'b0);
            random_op(isa_pkg::ADD, 1'b1, 1'b1, 1'b0);
            random_op(isa_pkg::SL,  1'b0, 1'b0, 1'b0);
            random_op(isa_pkg::SR,  1'b0, 1'b0, 1'b0);
            random_op(isa_pkg::SR,  1'b1, 1'b0, 1'b0);
            random_op(isa_pkg::XOR, 1'b0, 1'b0, 1'b0);
            random_op(isa_pkg::OR,  1'b0, 1'b0, 1'b0);
            random_op(isa_pkg::AND, 1'b0, 1'b0, 1'b0);
        end

        // divu / remu, zero divisor, divisor above dividend
        for (int n = 0; n < 3; n++) begin
            random_op(isa_pkg::DIVU, 1'b0, 1'b0, 1'b1);
            random_op(isa_pkg::REMU, 1'b0, 1'b0, 1'b1);
        end
        rand_word(a);
        rand_word(b);
        run_one(isa_pkg::DIVU, 1'b0, 1'b0, 1'b1, a, '0);
        run_one(isa_pkg::REMU, 1'b0, 1'b0, 1'b1, a, '0);
        run_one(isa_pkg::DIVU, 1'b0, 1'b0, 1'b1, a & 32'h00ff_ffff, b | 32'h0100_0000);
        run_one(isa_pkg::REMU, 1'b0, 1'b0, 1'b1, a & 32'h00ff_ffff, b | 32'h0100_0000);

        // other extension codes give zero
        random_op(isa_pkg::ADD, 1'b0, 1'b0, 1'b1);
        random_op(isa_pkg::SL,  1'b1, 1'b0, 1'b1);
        random_op(isa_pkg::XOR, 1'b0, 1'b0, 1'b1);
        random_op(isa_pkg::REM, 1'b0, 1'b0, 1'b1);

        // back to back, third order waits behind the divider
        send(isa_pkg::DIVU, 1'b0, 1'b0, 1'b1, a, b >> 4);
        send(isa_pkg::XOR, 1'b0, 1'b0, 1'b0, b, a);
        send(isa_pkg::AND, 1'b0, 1'b0, 1'b0, a, b);
        if (stall_cycles == 0) begin
            $display("accepted stayed high while the issue register was full");
            other_errors++;
        end
        send(isa_pkg::ADD, 1'b1, 1'b0, 1'b0, a, b);
        send(isa_pkg::REMU, 1'b0, 1'b0, 1'b1, b, a >> 8);
        send(isa_pkg::DIVU, 1'b0, 1'b0, 1'b1, a, 32'd7);
        send(isa_pkg::SR, 1'b1, 1'b0, 1'b0, b, a);
        order <= 1'b0;
        drain();
        repeat (3) @(posedge clk);
        finish_run();
    end

endmodule

//--- vlog.f
design/isa_pkg.sv
design/exec_pkg.sv
design/exec_if.sv
design/op_issue.sv
design/div_unsigned.sv
design/alu.sv
design/exec_unit.sv
testbench/tb_clock.sv
testbench/tb_exec_unit.sv

//--- run.sh
#!/bin/sh
# build and run the exec_unit testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exec_unit -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
